// File: sim.f
hw/settings_map_pkg.sv
hw/radio_types_pkg.sv
hw/time_ctrl_if.sv
hw/radio_settings.sv
hw/pps_capture.sv
hw/time_keeper.sv
hw/dbsrx_clk_gen.sv
hw/radio_core_top.sv
verif/radio_core_checker.sv
verif/tb_radio_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the radio core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing \
   -f sim.f \
   --top-module tb_radio_core \
   -Mdir obj_dir

./obj_dir/Vtb_radio_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

// File: verif/tb_radio_core.sv
// Testbench for radio_core_top. Applies a table of settings writes, then
// drives PPS pulses on both connectors and loads a random seconds value.
`timescale 1ns/1ps

module tb_radio_core;
   import settings_map_pkg::*;
   import radio_types_pkg::*;

   typedef struct packed {
      set_addr_t   addr;
      set_data_t   data;
      logic        clk_status;
      logic        link_up;
      logic [13:0] exp_ctrl;
      led_t        exp_leds;
   } wr_entry_t;

   localparam int N_ENTRIES  = 12;
   localparam int WAIT_LIMIT = 40;

   logic        dsp_clk = 1'b0;
   logic        dsp_rst;
   logic        set_stb;
   set_addr_t   set_addr;
   set_data_t   set_data;
   logic        clk_status;
   logic        link_up;
   logic        pps_in;
   logic        exp_pps_in;
   logic        clock_ready;
   logic [1:0]  clk_en;
   logic [1:0]  clk_sel;
   logic        ser_enable;
   logic        ser_prbsen;
   logic        ser_loopen;
   logic        ser_rx_en;
   logic        adc_oe_a;
   logic        adc_on_a;
   logic        adc_oe_b;
   logic        adc_on_b;
   logic        phy_reset_n;
   led_t        leds;
   logic        dbsrx_clk;
   logic        pps_int;
   secs_t       time_secs;
   ticks_t      time_ticks;

   logic        check_stb;
   logic [13:0] exp_ctrl;
   led_t        exp_leds;
   logic        pps_expect;
   secs_t       exp_secs;
   int          chk_errors;
   int          tb_errors;
   logic [31:0] lfsr_state;
   secs_t       load_val;
   wr_entry_t   wr_table [N_ENTRIES];

   always #20 dsp_clk = ~dsp_clk;

   radio_core_top radio_core_top_inst (
      .dsp_clk(dsp_clk), .dsp_rst(dsp_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .clk_status_i(clk_status), .serdes_link_up_i(link_up),
      .pps_in_i(pps_in), .exp_pps_in_i(exp_pps_in),
      .clock_ready_o(clock_ready), .clk_en_o(clk_en), .clk_sel_o(clk_sel),
      .ser_enable_o(ser_enable), .ser_prbsen_o(ser_prbsen),
      .ser_loopen_o(ser_loopen), .ser_rx_en_o(ser_rx_en),
      .adc_oe_a_o(adc_oe_a), .adc_on_a_o(adc_on_a),
      .adc_oe_b_o(adc_oe_b), .adc_on_b_o(adc_on_b),
      .phy_reset_n_o(phy_reset_n), .leds_o(leds),
      .dbsrx_clk_o(dbsrx_clk), .pps_int_o(pps_int),
      .time_secs_o(time_secs), .time_ticks_o(time_ticks)
   );

   radio_core_checker checker_inst (
      .dsp_clk(dsp_clk), .dsp_rst(dsp_rst),
      .check_stb_i(check_stb), .exp_ctrl_i(exp_ctrl), .exp_leds_i(exp_leds),
      .pps_expect_i(pps_expect), .exp_secs_i(exp_secs),
      .ctrl_i({clock_ready, clk_en, clk_sel, ser_enable, ser_prbsen, ser_loopen,
               ser_rx_en, adc_oe_a, adc_on_a, adc_oe_b, adc_on_b, phy_reset_n}),
      .leds_i(leds), .dbsrx_clk_i(dbsrx_clk), .pps_int_i(pps_int),
      .time_secs_i(time_secs), .time_ticks_i(time_ticks),
      .error_count_o(chk_errors)
   );

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_word(output logic [31:0] w);
      w = '0;
      for (int i = 0; i < 32; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         w = {w[30:0], lfsr_state[0]};
      end
   endtask

   task automatic write_setting(input set_addr_t addr, input set_data_t data);
      @(posedge dsp_clk);
      set_stb  <= 1'b1;
      set_addr <= addr;
      set_data <= data;
      @(posedge dsp_clk);
      set_stb <= 1'b0;
   endtask

   // Waits for a pulse on pps_int_o or on dbsrx_clk_o
   task automatic wait_pulse(input logic on_pps, input string what);
      logic seen;
      seen = 1'b0;
      for (int n = 0; n < WAIT_LIMIT && !seen; n++) begin
         @(posedge dsp_clk);
         seen = on_pps ? pps_int : dbsrx_clk;
      end
      if (!seen) begin
         $display("Timeout at %0t ns waiting for %s", $time, what);
         tb_errors++;
      end
   endtask

   // One PPS pulse on the chosen connector that should give new_secs
   task automatic send_pps(input logic use_exp, input secs_t new_secs);
      @(posedge dsp_clk);
      exp_secs   <= new_secs;
      pps_expect <= 1'b1;
      if (use_exp) begin
         exp_pps_in <= 1'b1;
      end else begin
         pps_in <= 1'b1;
      end
      wait_pulse(1'b1, "pps_int_o");
      @(posedge dsp_clk);
      pps_in     <= 1'b0;
      exp_pps_in <= 1'b0;
      pps_expect <= 1'b0;
      repeat (4) @(posedge dsp_clk);
   endtask

   // Pulse on the main connector while the expansion one is selected
   task automatic send_ignored_pps();
      @(posedge dsp_clk);
      pps_in <= 1'b1;
      repeat (4) @(posedge dsp_clk);
      pps_in <= 1'b0;
      repeat (6) @(posedge dsp_clk);
   endtask

   initial begin
      lfsr_state = 32'h2341_d60b;
      dsp_rst    = 1'b1;
      set_stb    = 1'b0;
      set_addr   = '0;
      set_data   = '0;
      clk_status = 1'b0;
      link_up    = 1'b0;
      pps_in     = 1'b0;
      exp_pps_in = 1'b0;
      check_stb  = 1'b0;
      exp_ctrl   = '0;
      exp_leds   = '0;
      pps_expect = 1'b0;
      exp_secs   = '0;
      tb_errors  = 0;
      load_val   = '0;

      // Control word order is clock 5, serdes 4, adc 4 and phy_reset_n
      wr_table[0]  = '{8'd5, 32'hffff_ffff, 1'b0, 1'b0, {5'b00000, 8'h00, 1'b1}, 8'h00};
      wr_table[1]  = '{SR_CLOCK, 32'h15, 1'b0, 1'b0, {5'b10101, 8'h00, 1'b1}, 8'h00};
      wr_table[2]  = '{SR_SERDES, 32'ha, 1'b0, 1'b0, {5'b10101, 8'ha0, 1'b1}, 8'h00};
      wr_table[3]  = '{SR_ADC, 32'h6, 1'b0, 1'b0, {5'b10101, 8'ha6, 1'b1}, 8'h00};
      wr_table[4]  = '{SR_PHY, 32'h1, 1'b0, 1'b0, {5'b10101, 8'ha6, 1'b0}, 8'h00};
      wr_table[5]  = '{8'd7, 32'hff, 1'b0, 1'b0, {5'b10101, 8'ha6, 1'b0}, 8'h00};
      wr_table[6]  = '{SR_PHY, 32'hffff_fffe, 1'b0, 1'b0, {5'b10101, 8'ha6, 1'b1}, 8'h00};
      wr_table[7]  = '{SR_LED_SW, 32'ha5, 1'b0, 1'b0, {5'b10101, 8'ha6, 1'b1}, 8'ha5};
      wr_table[8]  = '{SR_LED_SRC, 32'h0f, 1'b1, 1'b0, {5'b10101, 8'ha6, 1'b1}, 8'ha2};
      wr_table[9]  = '{8'd6, 32'h0, 1'b0, 1'b1, {5'b10101, 8'ha6, 1'b1}, 8'ha1};
      wr_table[10] = '{SR_LED_SRC, 32'h03, 1'b1, 1'b1, {5'b10101, 8'ha6, 1'b1}, 8'ha7};
      wr_table[11] = '{SR_LED_SW, 32'h00, 1'b0, 1'b1, {5'b10101, 8'ha6, 1'b1}, 8'h01};

      repeat (4) @(posedge dsp_clk);
      dsp_rst <= 1'b0;

      /////////////////////////////////////////////////////////////////////
      // Settings table
      /////////////////////////////////////////////////////////////////////
      for (int i = 0; i < N_ENTRIES; i++) begin
         @(posedge dsp_clk);
         clk_status <= wr_table[i].clk_status;
         link_up    <= wr_table[i].link_up;
         write_setting(wr_table[i].addr, wr_table[i].data);
         @(posedge dsp_clk);
         check_stb <= 1'b1;
         exp_ctrl  <= wr_table[i].exp_ctrl;
         exp_leds  <= wr_table[i].exp_leds;
         @(posedge dsp_clk);
         check_stb <= 1'b0;
      end

      // Let the checker see a couple of dbsrx intervals
      wait_pulse(1'b0, "dbsrx_clk_o");
      wait_pulse(1'b0, "dbsrx_clk_o");

      /////////////////////////////////////////////////////////////////////
      // PPS and time keeping
      /////////////////////////////////////////////////////////////////////
      send_pps(1'b0, 32'd1);
      send_pps(1'b0, 32'd2);
      draw_word(load_val);
      write_setting(SR_TIME_SECS, load_val);
      send_pps(1'b0, load_val);
      send_pps(1'b0, load_val + 32'd1);

      // Expansion input with falling edge sampling
      write_setting(SR_TIME_CTRL, 32'h3);
      send_ignored_pps();
      send_pps(1'b1, load_val + 32'd2);
      write_setting(SR_TIME_CTRL, 32'h1);
      send_pps(1'b1, load_val + 32'd3);

      repeat (2) @(posedge dsp_clk);
      $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
      if (chk_errors + tb_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: verif/radio_core_checker.sv
// Watches the radio core ports and compares them with the expected values.
// Also checks the dbsrx pulse spacing and the ticks/seconds rules on its own.
`timescale 1ns/1ps

module radio_core_checker (
   input  logic                    dsp_clk,
   input  logic                    dsp_rst,
   // Expected values from the stimulus table
   input  logic                    check_stb_i,
   input  logic [13:0]             exp_ctrl_i,
   input  radio_types_pkg::led_t   exp_leds_i,
   input  logic                    pps_expect_i,
   input  radio_types_pkg::secs_t  exp_secs_i,
   // Observed DUT outputs
   input  logic [13:0]             ctrl_i,
   input  radio_types_pkg::led_t   leds_i,
   input  logic                    dbsrx_clk_i,
   input  logic                    pps_int_i,
   input  radio_types_pkg::secs_t  time_secs_i,
   input  radio_types_pkg::ticks_t time_ticks_i,
   output int                      error_count_o
);
   import radio_types_pkg::*;

   logic   rst_d = 1'b0;
   secs_t  prev_secs;
   ticks_t prev_ticks;
   int     gap;
   int     errors = 0;

   assign error_count_o = errors;

   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] got_v);
      if (got_v !== exp_v) begin
         $display("** Error at %0t ns: %s expected %0h, got %0h",
                  $time, name, exp_v, got_v);
         errors++;
      end
   endtask

   always @(posedge dsp_clk) begin
      rst_d      <= dsp_rst;
      prev_secs  <= time_secs_i;
      prev_ticks <= time_ticks_i;

      // Table compare
      if (check_stb_i) begin
         check_val("control lines", 32'(exp_ctrl_i), 32'(ctrl_i));
         check_val("leds_o", 32'(exp_leds_i), 32'(leds_i));
      end

      if (dsp_rst) begin
         gap <= 1;
      end else if (rst_d) begin
         // First look at the outputs after reset
         gap <= 1;
         check_val("time_secs_o", 32'd0, time_secs_i);
         check_val("time_ticks_o", 32'd0, time_ticks_i);
         check_val("pps_int_o", 32'd0, 32'(pps_int_i));
         check_val("dbsrx_clk_o", 32'd0, 32'(dbsrx_clk_i));
      end else begin
         // Daughterboard clock spacing
         if (dbsrx_clk_i) begin
            check_val("dbsrx_clk_o spacing", 32'd25, 32'(gap));
            gap <= 1;
         end else if (gap >= 25) begin
            $display("Missing dbsrx_clk_o pulse at %0t ns", $time);
            errors++;
            gap <= 1;
         end else begin
            gap <= gap + 1;
         end

         // Time rules
         if (pps_int_i) begin
            if (!pps_expect_i) begin
               $display("Unexpected PPS update at %0t ns", $time);
               errors++;
            end
            check_val("time_ticks_o", 32'd0, time_ticks_i);
            check_val("time_secs_o", exp_secs_i, time_secs_i);
         end else begin
            check_val("time_ticks_o", prev_ticks + 32'd1, time_ticks_i);
            check_val("time_secs_o", prev_secs, time_secs_i);
         end
      end
   end

endmodule

// File: hw/radio_core_top.sv
// dsp_clk housekeeping top level. Settings registers, LEDs, daughterboard
// clock enable and PPS time keeping, wired together.
`timescale 1ns/1ps

module radio_core_top (
   input  logic                        dsp_clk,
   input  logic                        dsp_rst,
   // Settings bus
   input  logic                        set_stb_i,
   input  settings_map_pkg::set_addr_t set_addr_i,
   input  settings_map_pkg::set_data_t set_data_i,
   // Status inputs
   input  logic                        clk_status_i,
   input  logic                        serdes_link_up_i,
   // PPS
   input  logic                        pps_in_i,
   input  logic                        exp_pps_in_i,
   // Clock generator
   output logic                        clock_ready_o,
   output logic [1:0]                  clk_en_o,
   output logic [1:0]                  clk_sel_o,
   // SERDES control
   output logic                        ser_enable_o,
   output logic                        ser_prbsen_o,
   output logic                        ser_loopen_o,
   output logic                        ser_rx_en_o,
   // ADC control
   output logic                        adc_oe_a_o,
   output logic                        adc_on_a_o,
   output logic                        adc_oe_b_o,
   output logic                        adc_on_b_o,
   output logic                        phy_reset_n_o,
   output radio_types_pkg::led_t       leds_o,
   // Daughterboard clock and time
   output logic                        dbsrx_clk_o,
   output logic                        pps_int_o,
   output radio_types_pkg::secs_t      time_secs_o,
   output radio_types_pkg::ticks_t     time_ticks_o
);

   logic pps_pulse;

   time_ctrl_if time_ctrl ();

   radio_settings radio_settings_inst (
      .dsp_clk          (dsp_clk),
      .dsp_rst          (dsp_rst),
      .set_stb_i        (set_stb_i),
      .set_addr_i       (set_addr_i),
      .set_data_i       (set_data_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .adc_on_b_o       (adc_on_b_o),
      .phy_reset_n_o    (phy_reset_n_o),
      .leds_o           (leds_o),
      .time_ctrl        (time_ctrl.settings)
   );

   pps_capture pps_capture_inst (
      .dsp_clk      (dsp_clk),
      .dsp_rst      (dsp_rst),
      .pps_in_i     (pps_in_i),
      .exp_pps_in_i (exp_pps_in_i),
      .time_ctrl    (time_ctrl.capture),
      .pps_pulse_o  (pps_pulse)
   );

   time_keeper time_keeper_inst (
      .dsp_clk      (dsp_clk),
      .dsp_rst      (dsp_rst),
      .pps_pulse_i  (pps_pulse),
      .time_ctrl    (time_ctrl.keeper),
      .time_secs_o  (time_secs_o),
      .time_ticks_o (time_ticks_o),
      .pps_int_o    (pps_int_o)
   );

   dbsrx_clk_gen dbsrx_clk_gen_inst (
      .dsp_clk     (dsp_clk),
      .dsp_rst     (dsp_rst),
      .dbsrx_clk_o (dbsrx_clk_o)
   );

endmodule

// File: hw/dbsrx_clk_gen.sv
// Clock enable for the receive daughterboard with one dsp_clk pulse
// every DBSRX_DIV cycles.
`timescale 1ns/1ps

module dbsrx_clk_gen (
   input  logic dsp_clk,
   input  logic dsp_rst,
   output logic dbsrx_clk_o
);
   import radio_types_pkg::*;

   dbsrx_cnt_t cnt;
   logic       cnt_last;

   assign cnt_last = (cnt == dbsrx_cnt_t'(DBSRX_DIV - 1));

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         cnt         <= '0;
         dbsrx_clk_o <= 1'b0;
      end else begin
         cnt         <= cnt_last ? '0 : cnt + dbsrx_cnt_t'(1);
         dbsrx_clk_o <= cnt_last;
      end
   end

endmodule

// File: hw/time_keeper.sv
// Seconds and ticks counter. A seconds value written over the settings bus
// is loaded at the next PPS; otherwise each PPS adds one second.
`timescale 1ns/1ps

module time_keeper (
   input  logic                    dsp_clk,
   input  logic                    dsp_rst,
   input  logic                    pps_pulse_i,
   time_ctrl_if.keeper             time_ctrl,
   output radio_types_pkg::secs_t  time_secs_o,
   output radio_types_pkg::ticks_t time_ticks_o,
   output logic                    pps_int_o
);
   import radio_types_pkg::*;

   logic   armed;
   logic   load_now;
   secs_t  secs_r;
   ticks_t ticks_r;

   // A load request in the PPS cycle itself already has its value
   assign load_now = armed | time_ctrl.load_stb;

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         armed     <= 1'b0;
         secs_r    <= '0;
         ticks_r   <= '0;
         pps_int_o <= 1'b0;
      end else begin
         pps_int_o <= pps_pulse_i;
         if (pps_pulse_i) begin
            ticks_r <= '0;
            if (load_now) begin
               secs_r <= time_ctrl.secs_pending;
               armed  <= 1'b0;
            end else begin
               secs_r <= secs_r + secs_t'(1);
            end
         end else begin
            ticks_r <= ticks_r + ticks_t'(1);
            if (time_ctrl.load_stb) begin
               armed <= 1'b1;
            end
         end
      end
   end

   assign time_secs_o  = secs_r;
   assign time_ticks_o = ticks_r;

endmodule

// File: hw/pps_capture.sv
// PPS input capture. Samples the selected PPS source on either clock edge
// and gives one dsp_clk pulse per rising transition.
`timescale 1ns/1ps

module pps_capture (
   input  logic          dsp_clk,
   input  logic          dsp_rst,
   input  logic          pps_in_i,
   input  logic          exp_pps_in_i,
   time_ctrl_if.capture  time_ctrl,
   output logic          pps_pulse_o
);
   import radio_types_pkg::*;

   logic pps_sel;
   logic pps_pos;
   logic pps_neg;
   logic pps_pick;
   logic pps_pick_d1;

   // Main or expansion connector
   assign pps_sel = time_ctrl.pps_src_exp ? exp_pps_in_i : pps_in_i;

   // Falling edge sample, half a cycle earlier than the rising one
   always_ff @(negedge dsp_clk) begin
      if (dsp_rst) begin
         pps_neg <= 1'b0;
      end else begin
         pps_neg <= pps_sel;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         pps_pos <= 1'b0;
      end else begin
         pps_pos <= pps_sel;
      end
   end

   assign pps_pick = (time_ctrl.pps_edge == PPS_FALL) ? pps_neg : pps_pos;

   // Back in the rising edge domain
   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         pps_pick_d1 <= 1'b0;
      end else begin
         pps_pick_d1 <= pps_pick;
      end
   end

   // Low to high change of the picked sample
   assign pps_pulse_o = pps_pick & ~pps_pick_d1;

endmodule

// File: hw/radio_settings.sv
// Settings bus register bank. Drives the clock generator, SERDES, ADC and PHY
// control lines, the LED mux and the time control interface.
`timescale 1ns/1ps

module radio_settings (
   input  logic                       dsp_clk,
   input  logic                       dsp_rst,
   input  logic                       set_stb_i,
   input  settings_map_pkg::set_addr_t set_addr_i,
   input  settings_map_pkg::set_data_t set_data_i,
   input  logic                       clk_status_i,
   input  logic                       serdes_link_up_i,
   output logic                       clock_ready_o,
   output logic [1:0]                 clk_en_o,
   output logic [1:0]                 clk_sel_o,
   output logic                       ser_enable_o,
   output logic                       ser_prbsen_o,
   output logic                       ser_loopen_o,
   output logic                       ser_rx_en_o,
   output logic                       adc_oe_a_o,
   output logic                       adc_on_a_o,
   output logic                       adc_oe_b_o,
   output logic                       adc_on_b_o,
   output logic                       phy_reset_n_o,
   output radio_types_pkg::led_t      leds_o,
   time_ctrl_if.settings              time_ctrl
);
   import settings_map_pkg::*;
   import radio_types_pkg::*;

   logic [SR_CLOCK_W-1:0]     clock_r;
   logic [SR_SERDES_W-1:0]    serdes_r;
   logic [SR_ADC_W-1:0]       adc_r;
   logic [SR_PHY_W-1:0]       phy_r;
   logic [SR_TIME_CTRL_W-1:0] time_ctrl_r;
   led_t                      led_sw_r;
   led_t                      led_src_r;
   led_t                      led_hw;
   secs_t                     secs_r;
   logic                      load_r;

   //////////////////////////////////////////////////////////////////////
   // Register writes
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (dsp_rst) begin
         clock_r     <= '0;
         serdes_r    <= '0;
         adc_r       <= '0;
         phy_r       <= '0;
         time_ctrl_r <= '0;
         led_sw_r    <= '0;
         led_src_r   <= '0;
         secs_r      <= '0;
         load_r      <= 1'b0;
      end else begin
         load_r <= 1'b0;
         if (set_stb_i) begin
            case (set_addr_i)
               SR_CLOCK:     clock_r     <= set_data_i[SR_CLOCK_W-1:0];
               SR_SERDES:    serdes_r    <= set_data_i[SR_SERDES_W-1:0];
               SR_ADC:       adc_r       <= set_data_i[SR_ADC_W-1:0];
               SR_PHY:       phy_r       <= set_data_i[SR_PHY_W-1:0];
               SR_LED_SW:    led_sw_r    <= set_data_i[$bits(led_t)-1:0];
               SR_LED_SRC:   led_src_r   <= set_data_i[$bits(led_t)-1:0];
               SR_TIME_CTRL: time_ctrl_r <= set_data_i[SR_TIME_CTRL_W-1:0];
               SR_TIME_SECS: begin
                  secs_r <= set_data_i;
                  load_r <= 1'b1;
               end
               // Unmapped addresses belong to other blocks
               default: ;
            endcase
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Control lines
   //////////////////////////////////////////////////////////////////////

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_r;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_r;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_r;

   // PHY reset pin is active low
   assign phy_reset_n_o = ~phy_r[0];

   // LED mux, 1 in led_src selects the hardware status bit
   always_comb begin
      led_hw               = '0;
      led_hw[LED_CLK_BIT]  = clk_status_i;
      led_hw[LED_LINK_BIT] = serdes_link_up_i;
   end

   assign leds_o = (led_src_r & led_hw) | (~led_src_r & led_sw_r);

   // Time control
   assign time_ctrl.secs_pending = secs_r;
   assign time_ctrl.load_stb     = load_r;
   assign time_ctrl.pps_src_exp  = time_ctrl_r[TC_EXP_BIT];
   assign time_ctrl.pps_edge     = time_ctrl_r[TC_FALL_BIT] ? PPS_FALL : PPS_RISE;

endmodule

// File: hw/time_ctrl_if.sv
// Time control from the settings registers to the PPS capture and time keeper.
`timescale 1ns/1ps

interface time_ctrl_if;
   import radio_types_pkg::*;

   // Seconds value waiting for the next PPS
   secs_t     secs_pending;
   // One cycle after SR_TIME_SECS is written
   logic      load_stb;
   // PPS source and sampling edge
   logic      pps_src_exp;
   pps_edge_e pps_edge;

   modport settings (
      output secs_pending,
      output load_stb,
      output pps_src_exp,
      output pps_edge
   );

   modport capture (input pps_src_exp, input pps_edge);

   modport keeper (input secs_pending, input load_stb);

endinterface

// File: hw/radio_types_pkg.sv
// Time, divider and LED types shared by the dsp_clk housekeeping blocks.
package radio_types_pkg;

   // Time of day
   typedef logic [31:0] secs_t;
   typedef logic [31:0] ticks_t;

   // Front panel LEDs
   typedef logic [7:0] led_t;

   // Hardware LED bit positions
   localparam int unsigned LED_LINK_BIT = 0;
   localparam int unsigned LED_CLK_BIT  = 1;

   // Receive daughterboard clock divider
   typedef logic [4:0] dbsrx_cnt_t;
   localparam int unsigned DBSRX_DIV = 25;

   // Clock edge used to sample the PPS input
   typedef enum logic {
      PPS_RISE = 1'b0,
      PPS_FALL = 1'b1
   } pps_edge_e;

endpackage

// File: hw/settings_map_pkg.sv
// Settings bus address map and register field widths.
// Imported by the settings decoder and by anything that builds bus writes.
package settings_map_pkg;

   // Settings bus word types
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Register addresses
   localparam set_addr_t SR_CLOCK     = 8'd0;
   localparam set_addr_t SR_SERDES    = 8'd1;
   localparam set_addr_t SR_ADC       = 8'd2;
   localparam set_addr_t SR_LED_SW    = 8'd3;
   localparam set_addr_t SR_PHY       = 8'd4;
   localparam set_addr_t SR_LED_SRC   = 8'd8;
   localparam set_addr_t SR_TIME_SECS = 8'd9;
   localparam set_addr_t SR_TIME_CTRL = 8'd10;

   // Field widths, low bits of the data word
   localparam int unsigned SR_CLOCK_W     = 5;
   localparam int unsigned SR_SERDES_W    = 4;
   localparam int unsigned SR_ADC_W       = 4;
   localparam int unsigned SR_PHY_W       = 1;
   localparam int unsigned SR_TIME_CTRL_W = 2;

   // SR_TIME_CTRL bits
   localparam int unsigned TC_EXP_BIT  = 0;
   localparam int unsigned TC_FALL_BIT = 1;

endpackage
